//--- logic/video_pkg.sv
// Video output path package
// Channel widths, colour vector types and the pixel structs passed between stages
`default_nettype none

package video_pkg;

    // Game colour channel width
    localparam int COLORW = 4;
    // One extra bit after the bandwidth filter
    localparam int BWW    = COLORW + 1;
    // Output channel width
    localparam int OUTW   = 8;

    typedef logic [COLORW-1:0] color_in_t;
    typedef logic [BWW-1:0]    color_bw_t;
    typedef logic [OUTW-1:0]   color_out_t;

    // Raw game pixel, blanking flags are active low
    typedef struct packed {
        color_in_t r;
        color_in_t g;
        color_in_t b;
        logic      lhbl;
        logic      lvbl;
        logic      hs;
        logic      vs;
    } vid_in_t;

    // Filtered pixel with widened channels
    typedef struct packed {
        color_bw_t r;
        color_bw_t g;
        color_bw_t b;
        logic      lhbl;
        logic      lvbl;
        logic      hs;
        logic      vs;
    } vid_bw_t;

    // Final 8-bit pixel with data enable
    typedef struct packed {
        color_out_t r;
        color_out_t g;
        color_out_t b;
        logic       hs;
        logic       vs;
        logic       de;
    } vid_out_t;

endpackage

`default_nettype wire

//--- logic/video_capture.sv
// Video capture stage
// Registers game colour, blanking and syncs on the pixel strobe and keeps the prior pixel
`timescale 1ns/1ps
`default_nettype none

module video_capture
    import video_pkg::*;
(
    input  logic    clk_sys,
    input  logic    rst_n,
    input  logic    pxl_cen,
    input  vid_in_t pxl_in,
    output vid_in_t pxl_out,
    output vid_in_t pxl_prev
);

    // Current pixel, isolates game timing from the output path
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pxl_out <= '0;
        end else if (pxl_cen) begin
            pxl_out <= pxl_in;
        end
    end

    // Pixel held one strobe earlier, used by the filter
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pxl_prev <= '0;
        end else if (pxl_cen) begin
            pxl_prev <= pxl_out;
        end
    end

endmodule

`default_nettype wire

//--- logic/bw_filter.sv
// Bandwidth limiting filter
// Averages each pixel with the one before it and widens every channel by one bit
`timescale 1ns/1ps
`default_nettype none

module bw_filter
    import video_pkg::*;
(
    input  logic    clk_sys,
    input  logic    rst_n,
    input  logic    pxl_cen,
    input  logic    bw_en,
    input  vid_in_t pxl_cur,
    input  vid_in_t pxl_prev,
    output vid_bw_t pxl_out
);

    vid_bw_t bw_next;

    // Sum of two neighbours, twice their average
    function automatic color_bw_t chan_sum(
        input color_in_t cur,
        input color_in_t prev
    );
        color_bw_t sum;
        sum = {1'b0, cur} + {1'b0, prev};
        return sum;
    endfunction

    // Bypass doubles the value so both modes share the same scale
    function automatic color_bw_t chan_dbl(input color_in_t cur);
        color_bw_t dbl;
        dbl = {cur, 1'b0};
        return dbl;
    endfunction

    // One channel through the selected mode
    function automatic color_bw_t chan_filt(
        input logic      en,
        input color_in_t cur,
        input color_in_t prev
    );
        color_bw_t res;
        if (en) begin
            res = chan_sum(cur, prev);
        end else begin
            res = chan_dbl(cur);
        end
        return res;
    endfunction

    always_comb begin
        bw_next.r    = chan_filt(bw_en, pxl_cur.r, pxl_prev.r);
        bw_next.g    = chan_filt(bw_en, pxl_cur.g, pxl_prev.g);
        bw_next.b    = chan_filt(bw_en, pxl_cur.b, pxl_prev.b);
        // Timing follows the current pixel so syncs stay with the colour
        bw_next.lhbl = pxl_cur.lhbl;
        bw_next.lvbl = pxl_cur.lvbl;
        bw_next.hs   = pxl_cur.hs;
        bw_next.vs   = pxl_cur.vs;
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pxl_out <= '0;
        end else if (pxl_cen) begin
            pxl_out <= bw_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/color_expand.sv
// Colour expansion stage
// Widens channels to 8 bits, forms data enable and blacks out the colour during blanking
`timescale 1ns/1ps
`default_nettype none

module color_expand
    import video_pkg::*;
(
    input  logic     clk_sys,
    input  logic     rst_n,
    input  logic     pxl_cen,
    input  vid_bw_t  pxl_in,
    output vid_out_t pxl_out
);

    logic     de;
    vid_out_t exp_next;

    // Top bits repeated into the low end so full scale maps to 0xff
    function automatic color_out_t extend8(input color_bw_t c);
        color_out_t res;
        res = {c, c[BWW-1:BWW-3]};
        return res;
    endfunction

    // Both blanking flags are active low
    assign de = pxl_in.lhbl & pxl_in.lvbl;

    always_comb begin
        if (de) begin
            exp_next.r = extend8(pxl_in.r);
            exp_next.g = extend8(pxl_in.g);
            exp_next.b = extend8(pxl_in.b);
        end else begin
            exp_next.r = '0;
            exp_next.g = '0;
            exp_next.b = '0;
        end
        exp_next.hs = pxl_in.hs;
        exp_next.vs = pxl_in.vs;
        exp_next.de = de;
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pxl_out <= '0;
        end else if (pxl_cen) begin
            pxl_out <= exp_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/video_out_top.sv
// Analog-style video output path
// Capture, bandwidth filter and 8-bit expansion chained on the pixel strobe
`timescale 1ns/1ps
`default_nettype none

module video_out_top
    import video_pkg::*;
(
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       bw_en,
    // Game video
    input  color_in_t  game_r,
    input  color_in_t  game_g,
    input  color_in_t  game_b,
    input  logic       lhbl,
    input  logic       lvbl,
    input  logic       hs,
    input  logic       vs,
    // Output video
    output color_out_t video_r,
    output color_out_t video_g,
    output color_out_t video_b,
    output logic       video_hs,
    output logic       video_vs,
    output logic       video_de
);

    vid_in_t  game_pxl;
    vid_in_t  cap_pxl;
    vid_in_t  cap_prev;
    vid_bw_t  bw_pxl;
    vid_out_t out_pxl;

    assign game_pxl = '{r: game_r, g: game_g, b: game_b,
                        lhbl: lhbl, lvbl: lvbl, hs: hs, vs: vs};

    video_capture u_capture (
        .clk_sys  ( clk_sys  ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pxl_in   ( game_pxl ),
        .pxl_out  ( cap_pxl  ),
        .pxl_prev ( cap_prev )
    );

    bw_filter u_bw_filter (
        .clk_sys  ( clk_sys  ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .bw_en    ( bw_en    ),
        .pxl_cur  ( cap_pxl  ),
        .pxl_prev ( cap_prev ),
        .pxl_out  ( bw_pxl   )
    );

    color_expand u_expand (
        .clk_sys  ( clk_sys  ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pxl_in   ( bw_pxl   ),
        .pxl_out  ( out_pxl  )
    );

    assign video_r  = out_pxl.r;
    assign video_g  = out_pxl.g;
    assign video_b  = out_pxl.b;
    assign video_hs = out_pxl.hs;
    assign video_vs = out_pxl.vs;
    assign video_de = out_pxl.de;

endmodule

`default_nettype wire

//--- verif/video_model.svh
// Reference model of the video output path
// Capture history, filter slot and output slot, advanced once per pixel strobe
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

// Last two captured pixels
vid_in_t  model_cap;
vid_in_t  model_prev;
// Filter slot and output slot
vid_bw_t  model_bw;
vid_out_t model_out;

// Filtered channel, sum of neighbours or the current value doubled
function automatic color_bw_t filter_channel(
    input logic      en,
    input color_in_t cur,
    input color_in_t prev
);
    int total;
    if (en) begin
        total = int'(cur) + int'(prev);
    end else begin
        total = 2 * int'(cur);
    end
    return color_bw_t'(total);
endfunction

// Five bits moved up by three, with their top three bits repeated below
function automatic color_out_t expand_channel(input color_bw_t v);
    int wide;
    wide = int'(v) * 8 + int'(v) / 4;
    return color_out_t'(wide);
endfunction

task automatic reset_model();
    model_cap  = '0;
    model_prev = '0;
    model_bw   = '0;
    model_out  = '0;
endtask

// One strobe, all slots move together from their old values
task automatic step_model(input vid_in_t in_pxl, input logic en);
    vid_out_t next_out;
    vid_bw_t  next_bw;
    logic     de;
    de = model_bw.lhbl && model_bw.lvbl;
    next_out.r  = de ? expand_channel(model_bw.r) : '0;
    next_out.g  = de ? expand_channel(model_bw.g) : '0;
    next_out.b  = de ? expand_channel(model_bw.b) : '0;
    next_out.hs = model_bw.hs;
    next_out.vs = model_bw.vs;
    next_out.de = de;
    next_bw.r    = filter_channel(en, model_cap.r, model_prev.r);
    next_bw.g    = filter_channel(en, model_cap.g, model_prev.g);
    next_bw.b    = filter_channel(en, model_cap.b, model_prev.b);
    next_bw.lhbl = model_cap.lhbl;
    next_bw.lvbl = model_cap.lvbl;
    next_bw.hs   = model_cap.hs;
    next_bw.vs   = model_cap.vs;
    model_out  = next_out;
    model_bw   = next_bw;
    model_prev = model_cap;
    model_cap  = in_pxl;
endtask

`endif

//--- verif/video_out_tb.sv
// Testbench for the video output path
// Random pixels on a random strobe are compared against a reference model
`timescale 1ns/1ps
`default_nettype none

module video_out_tb
    import video_pkg::*;
();

    logic       clk_sys;
    logic       rst_n;
    logic       pxl_cen;
    logic       bw_en;
    vid_in_t    stim;
    color_out_t video_r;
    color_out_t video_g;
    color_out_t video_b;
    logic       video_hs;
    logic       video_vs;
    logic       video_de;

    integer seed;
    int     checks;
    int     errors;
    int     strobes;
    int     reset_wait;
    int     cyc;

    `include "video_model.svh"

    video_out_top UUT (
        .clk_sys  ( clk_sys   ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .bw_en    ( bw_en     ),
        .game_r   ( stim.r    ),
        .game_g   ( stim.g    ),
        .game_b   ( stim.b    ),
        .lhbl     ( stim.lhbl ),
        .lvbl     ( stim.lvbl ),
        .hs       ( stim.hs   ),
        .vs       ( stim.vs   ),
        .video_r  ( video_r   ),
        .video_g  ( video_g   ),
        .video_b  ( video_b   ),
        .video_hs ( video_hs  ),
        .video_vs ( video_vs  ),
        .video_de ( video_de  )
    );

    initial begin
        clk_sys = 1'b0;
    end

    always #5 clk_sys = ~clk_sys;

    // Reset held for two clock cycles and released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        rst_n = 1'b1;
    end

    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    task automatic compare_outputs();
        check_value("video_r", int'(video_r), int'(model_out.r));
        check_value("video_g", int'(video_g), int'(model_out.g));
        check_value("video_b", int'(video_b), int'(model_out.b));
        check_value("video_hs", int'(video_hs), int'(model_out.hs));
        check_value("video_vs", int'(video_vs), int'(model_out.vs));
        check_value("video_de", int'(video_de), int'(model_out.de));
        // Colour must be black outside the active area
        if (!video_de) begin
            check_value("blanked colour", int'({video_r, video_g, video_b}), 0);
        end
    endtask

    // New values on every cycle whether or not it strobes
    task automatic drive_inputs();
        int rnd;
        rnd = $random(seed);
        pxl_cen = rnd[0];
        bw_en   = rnd[1];
        stim.hs = rnd[2];
        stim.vs = rnd[3];
        // Blanking flags high seven times in eight
        stim.lhbl = (rnd[6:4] != 3'd0);
        stim.lvbl = (rnd[9:7] != 3'd0);
        stim.r = color_in_t'($random(seed));
        stim.g = color_in_t'($random(seed));
        stim.b = color_in_t'($random(seed));
    endtask

    initial begin
        seed    = 32'h6862;
        checks  = 0;
        errors  = 0;
        strobes = 0;
        pxl_cen = 1'b0;
        bw_en   = 1'b0;
        stim    = '0;
        reset_model();

        reset_wait = 0;
        while (rst_n !== 1'b1 && reset_wait < 20) begin
            @(posedge clk_sys);
            reset_wait++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was not released within 20 clock cycles");
            $display("TEST FAILED");
        end else begin
            @(negedge clk_sys);
            for (cyc = 0; cyc < 2000; cyc++) begin
                // pxl_cen still holds the value seen at the last rising edge
                if (pxl_cen) begin
                    step_model(stim, bw_en);
                    strobes++;
                end
                compare_outputs();
                drive_inputs();
                @(negedge clk_sys);
            end

            $display("Checks: %0d, errors: %0d, strobes: %0d", checks, errors, strobes);
            if (errors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- video_out.f
+incdir+verif
logic/video_pkg.sv
logic/video_capture.sv
logic/bw_filter.sv
logic/color_expand.sv
logic/video_out_top.sv
verif/video_out_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the video output path simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module video_out_tb -f video_out.f -o video_out_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/video_out_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TEST PASSED$"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi
